//--- Makefile
# Verilator build and run of the ECDSA command controller testbench

VERILATOR ?= verilator
TOP       ?= tb_ecdsa_ctrl
FILELIST  ?= ecdsa_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || (echo "test target failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- ecdsa_ctrl.f
ecdsa_ctrl_pkg.sv
ecdsa_uop_if.sv
ecdsa_program_rom.sv
ecdsa_sequencer.sv
ecdsa_operand_mux.sv
ecdsa_result_bank.sv
ecdsa_ctrl_top.sv
tb_ecdsa_ctrl.sv

//--- ecdsa_ctrl_pkg.sv
//--------------------------------------------------------------------------
// Widths, P-384 constants, micro-op encodings and program addresses shared
// by the ECDSA command controller. Modules refer to these by scoped name.
//--------------------------------------------------------------------------
`default_nettype none

package ecdsa_ctrl_pkg;

    localparam int REG_SIZE    = 384;
    localparam int ADDR_W      = 6;
    localparam int PROG_ADDR_W = 6;

    typedef logic [REG_SIZE-1:0] operand_t;

    //------------------------------------------------------------------------
    // curve constants
    //------------------------------------------------------------------------
    localparam operand_t GROUP_ORDER = {
        192'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF,
        192'hC7634D81_F4372DDF_581A0DB2_48B0A77A_ECEC196A_CCC52973
    };

    localparam operand_t PRIME = {
        192'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF,
        192'hFFFFFFFF_FFFFFFFE_FFFFFFFF_00000000_00000000_FFFFFFFF
    };

    localparam operand_t ZERO_CONST = '0;
    localparam operand_t ONE_CONST  = 384'd1;

    //------------------------------------------------------------------------
    // encodings
    //------------------------------------------------------------------------
    typedef enum logic [1:0] {
        NOP_CMD = 2'b00,
        KEYGEN  = 2'b01,
        SIGN    = 2'b10,
        VERIFY  = 2'b11
    } cmd_e;

    typedef enum logic [1:0] {
        UOP_NOP,
        UOP_WR_CORE,
        UOP_RD_CORE,
        UOP_PM
    } opcode_e;

    typedef enum logic [3:0] {
        CONST_ZERO_ID,
        CONST_ONE_ID,
        MSG_ID,
        PRIVKEY_ID,
        PUBKEYX_ID,
        PUBKEYY_ID,
        R_ID,
        S_ID,
        VERIFY_R_ID
    } reg_id_e;

    // point-multiply commands understood by the arithmetic unit
    typedef enum logic [2:0] {
        PM_NONE,
        PM_KEYGEN,
        PM_SIGN,
        PM_VERIFY
    } pm_cmd_e;

    typedef struct packed {
        opcode_e           opcode;
        reg_id_e           reg_id;
        logic [ADDR_W-1:0] mem_addr;
        pm_cmd_e           pm_cmd;
    } instr_t;

    typedef enum logic [1:0] {
        PROC_IDLE,
        PROC_KEYGEN,
        PROC_SIGN,
        PROC_VERIFY
    } proc_e;

    // program layout, each end address holds a nop slot
    localparam logic [PROG_ADDR_W-1:0] DSA_NOP   = 6'd0;
    localparam logic [PROG_ADDR_W-1:0] DSA_KG_S  = 6'd1;
    localparam logic [PROG_ADDR_W-1:0] DSA_KG_E  = 6'd5;
    localparam logic [PROG_ADDR_W-1:0] DSA_SGN_S = 6'd8;
    localparam logic [PROG_ADDR_W-1:0] DSA_SGN_E = 6'd13;
    localparam logic [PROG_ADDR_W-1:0] DSA_VER_S = 6'd16;
    localparam logic [PROG_ADDR_W-1:0] DSA_VER_E = 6'd23;

    // four cycles per micro-op
    localparam logic [1:0] SLOT_LAST = 2'd3;

endpackage

`default_nettype wire

//--- ecdsa_ctrl_top.sv
//--------------------------------------------------------------------------
// ECDSA P-384 command controller top. Plain ports to the host side and to
// the external point-multiplication unit.
//--------------------------------------------------------------------------
`default_nettype none

module ecdsa_ctrl_top (
    input  wire                               clk,
    input  wire                               reset_n,
    input  wire                               zeroize_i,
    input  wire ecdsa_ctrl_pkg::cmd_e         cmd_i,
    input  wire ecdsa_ctrl_pkg::operand_t     msg_i,
    input  wire ecdsa_ctrl_pkg::operand_t     privkey_i,
    input  wire ecdsa_ctrl_pkg::operand_t     pubkey_x_i,
    input  wire ecdsa_ctrl_pkg::operand_t     pubkey_y_i,
    input  wire ecdsa_ctrl_pkg::operand_t     r_i,
    input  wire ecdsa_ctrl_pkg::operand_t     s_i,
    output logic                              ready_o,
    output logic                              valid_o,
    output logic                              done_o,
    output logic                              error_o,
    output ecdsa_ctrl_pkg::operand_t          pubkey_x_o,
    output ecdsa_ctrl_pkg::operand_t          pubkey_y_o,
    output ecdsa_ctrl_pkg::operand_t          r_o,
    output ecdsa_ctrl_pkg::operand_t          s_o,
    output ecdsa_ctrl_pkg::operand_t          verify_r_o,
    // point-multiplication unit
    output logic                              pm_wr_en_o,
    output logic                              pm_rd_en_o,
    output logic [ecdsa_ctrl_pkg::ADDR_W-1:0] pm_addr_o,
    output ecdsa_ctrl_pkg::operand_t          pm_wr_data_o,
    output ecdsa_ctrl_pkg::pm_cmd_e           pm_cmd_o,
    input  wire ecdsa_ctrl_pkg::operand_t     pm_rd_data_i,
    input  wire                               pm_busy_i
);

    logic input_err;

    ecdsa_uop_if uop_if ();

    ecdsa_sequencer sequencer_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .cmd_i     (cmd_i),
        .pm_busy_i (pm_busy_i),
        .ready_o   (ready_o),
        .valid_o   (valid_o),
        .pm_cmd_o  (pm_cmd_o),
        .uop       (uop_if.seq)
    );

    ecdsa_operand_mux operand_mux_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .msg_i        (msg_i),
        .privkey_i    (privkey_i),
        .pubkey_x_i   (pubkey_x_i),
        .pubkey_y_i   (pubkey_y_i),
        .r_i          (r_i),
        .s_i          (s_i),
        .uop          (uop_if.sink),
        .pm_wr_en_o   (pm_wr_en_o),
        .pm_addr_o    (pm_addr_o),
        .pm_wr_data_o (pm_wr_data_o),
        .input_err_o  (input_err)
    );

    ecdsa_result_bank result_bank_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .uop          (uop_if.sink),
        .input_err_i  (input_err),
        .valid_i      (valid_o),
        .pm_rd_data_i (pm_rd_data_i),
        .pm_rd_en_o   (pm_rd_en_o),
        .pubkey_x_o   (pubkey_x_o),
        .pubkey_y_o   (pubkey_y_o),
        .r_o          (r_o),
        .s_o          (s_o),
        .verify_r_o   (verify_r_o),
        .done_o       (done_o),
        .error_o      (error_o)
    );

endmodule

`default_nettype wire

//--- ecdsa_operand_mux.sv
//--------------------------------------------------------------------------
// Decode stage. Reduces the message modulo q, picks the operand for write
// micro-ops and checks the command inputs against the curve bounds.
//--------------------------------------------------------------------------
`default_nettype none

module ecdsa_operand_mux (
    input  wire                               clk,
    input  wire                               reset_n,
    input  wire                               zeroize_i,
    input  wire ecdsa_ctrl_pkg::operand_t     msg_i,
    input  wire ecdsa_ctrl_pkg::operand_t     privkey_i,
    input  wire ecdsa_ctrl_pkg::operand_t     pubkey_x_i,
    input  wire ecdsa_ctrl_pkg::operand_t     pubkey_y_i,
    input  wire ecdsa_ctrl_pkg::operand_t     r_i,
    input  wire ecdsa_ctrl_pkg::operand_t     s_i,
    ecdsa_uop_if.sink                         uop,
    output logic                              pm_wr_en_o,
    output logic [ecdsa_ctrl_pkg::ADDR_W-1:0] pm_addr_o,
    output ecdsa_ctrl_pkg::operand_t          pm_wr_data_o,
    output logic                              input_err_o
);

    ecdsa_ctrl_pkg::operand_t msg_red_q;
    ecdsa_ctrl_pkg::operand_t wr_sel;
    logic                     is_wr;
    logic                     is_rd;

    // scalar must lie in [1, q-1]
    function automatic logic out_of_q(input ecdsa_ctrl_pkg::operand_t v);
        return (v == '0) || (v >= ecdsa_ctrl_pkg::GROUP_ORDER);
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            msg_red_q <= '0;
        end else if (zeroize_i) begin
            msg_red_q <= '0;
        end else if (msg_i >= ecdsa_ctrl_pkg::GROUP_ORDER) begin
            msg_red_q <= msg_i - ecdsa_ctrl_pkg::GROUP_ORDER;
        end else begin
            msg_red_q <= msg_i;
        end
    end

    always_comb begin
        case (uop.instr.reg_id)
            ecdsa_ctrl_pkg::CONST_ZERO_ID: wr_sel = ecdsa_ctrl_pkg::ZERO_CONST;
            ecdsa_ctrl_pkg::CONST_ONE_ID:  wr_sel = ecdsa_ctrl_pkg::ONE_CONST;
            ecdsa_ctrl_pkg::MSG_ID:        wr_sel = msg_red_q;
            ecdsa_ctrl_pkg::PRIVKEY_ID:    wr_sel = privkey_i;
            ecdsa_ctrl_pkg::PUBKEYX_ID:    wr_sel = pubkey_x_i;
            ecdsa_ctrl_pkg::PUBKEYY_ID:    wr_sel = pubkey_y_i;
            ecdsa_ctrl_pkg::R_ID:          wr_sel = r_i;
            ecdsa_ctrl_pkg::S_ID:          wr_sel = s_i;
            default:                       wr_sel = '0;
        endcase
    end

    assign is_wr = uop.issue && (uop.instr.opcode == ecdsa_ctrl_pkg::UOP_WR_CORE);
    assign is_rd = uop.issue && (uop.instr.opcode == ecdsa_ctrl_pkg::UOP_RD_CORE);

    assign pm_wr_en_o   = is_wr;
    assign pm_addr_o    = (is_wr || is_rd) ? uop.instr.mem_addr : '0;
    assign pm_wr_data_o = is_wr ? wr_sel : '0;

    // checks only count while the matching program runs
    assign input_err_o =
        ((uop.proc == ecdsa_ctrl_pkg::PROC_SIGN) && out_of_q(privkey_i)) ||
        ((uop.proc == ecdsa_ctrl_pkg::PROC_VERIFY) &&
         (out_of_q(r_i) || out_of_q(s_i) ||
          (pubkey_x_i >= ecdsa_ctrl_pkg::PRIME) || (pubkey_y_i >= ecdsa_ctrl_pkg::PRIME)));

endmodule

`default_nettype wire

//--- ecdsa_program_rom.sv
//--------------------------------------------------------------------------
// Micro-program store for keygen, sign and verify. Registered read, so the
// word for an address shows up one cycle after the address.
//--------------------------------------------------------------------------
`default_nettype none

module ecdsa_program_rom (
    input  wire                                      clk,
    input  wire                                      reset_n,
    input  wire [ecdsa_ctrl_pkg::PROG_ADDR_W-1:0]    addr_i,
    output ecdsa_ctrl_pkg::instr_t                   instr_o
);

    ecdsa_ctrl_pkg::instr_t rom_word;

    function automatic ecdsa_ctrl_pkg::instr_t op_wr(input ecdsa_ctrl_pkg::reg_id_e id,
                                                     input logic [5:0] addr);
        return '{ecdsa_ctrl_pkg::UOP_WR_CORE, id, addr, ecdsa_ctrl_pkg::PM_NONE};
    endfunction

    function automatic ecdsa_ctrl_pkg::instr_t op_rd(input ecdsa_ctrl_pkg::reg_id_e id,
                                                     input logic [5:0] addr);
        return '{ecdsa_ctrl_pkg::UOP_RD_CORE, id, addr, ecdsa_ctrl_pkg::PM_NONE};
    endfunction

    function automatic ecdsa_ctrl_pkg::instr_t op_pm(input ecdsa_ctrl_pkg::pm_cmd_e cmd);
        return '{ecdsa_ctrl_pkg::UOP_PM, ecdsa_ctrl_pkg::CONST_ZERO_ID, 6'd0, cmd};
    endfunction

    // operand memory map: msg 2, privkey 3, r 4, s 5, x 6, y 7, verify_r 8
    always_comb begin
        case (addr_i)
            // keygen
            ecdsa_ctrl_pkg::DSA_KG_S:          rom_word = op_wr(ecdsa_ctrl_pkg::PRIVKEY_ID, 6'd3);
            ecdsa_ctrl_pkg::DSA_KG_S + 6'd1:   rom_word = op_pm(ecdsa_ctrl_pkg::PM_KEYGEN);
            ecdsa_ctrl_pkg::DSA_KG_S + 6'd2:   rom_word = op_rd(ecdsa_ctrl_pkg::PUBKEYX_ID, 6'd6);
            ecdsa_ctrl_pkg::DSA_KG_S + 6'd3:   rom_word = op_rd(ecdsa_ctrl_pkg::PUBKEYY_ID, 6'd7);
            // sign
            ecdsa_ctrl_pkg::DSA_SGN_S:         rom_word = op_wr(ecdsa_ctrl_pkg::MSG_ID, 6'd2);
            ecdsa_ctrl_pkg::DSA_SGN_S + 6'd1:  rom_word = op_wr(ecdsa_ctrl_pkg::PRIVKEY_ID, 6'd3);
            ecdsa_ctrl_pkg::DSA_SGN_S + 6'd2:  rom_word = op_pm(ecdsa_ctrl_pkg::PM_SIGN);
            ecdsa_ctrl_pkg::DSA_SGN_S + 6'd3:  rom_word = op_rd(ecdsa_ctrl_pkg::R_ID, 6'd4);
            ecdsa_ctrl_pkg::DSA_SGN_S + 6'd4:  rom_word = op_rd(ecdsa_ctrl_pkg::S_ID, 6'd5);
            // verify
            ecdsa_ctrl_pkg::DSA_VER_S:         rom_word = op_wr(ecdsa_ctrl_pkg::MSG_ID, 6'd2);
            ecdsa_ctrl_pkg::DSA_VER_S + 6'd1:  rom_word = op_wr(ecdsa_ctrl_pkg::R_ID, 6'd4);
            ecdsa_ctrl_pkg::DSA_VER_S + 6'd2:  rom_word = op_wr(ecdsa_ctrl_pkg::S_ID, 6'd5);
            ecdsa_ctrl_pkg::DSA_VER_S + 6'd3:  rom_word = op_wr(ecdsa_ctrl_pkg::PUBKEYX_ID, 6'd6);
            ecdsa_ctrl_pkg::DSA_VER_S + 6'd4:  rom_word = op_wr(ecdsa_ctrl_pkg::PUBKEYY_ID, 6'd7);
            ecdsa_ctrl_pkg::DSA_VER_S + 6'd5:  rom_word = op_pm(ecdsa_ctrl_pkg::PM_VERIFY);
            ecdsa_ctrl_pkg::DSA_VER_S + 6'd6:  rom_word = op_rd(ecdsa_ctrl_pkg::VERIFY_R_ID, 6'd8);
            // idle and end slots
            default:                           rom_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instr_o <= '0;
        end else begin
            instr_o <= rom_word;
        end
    end

endmodule

`default_nettype wire

//--- ecdsa_result_bank.sv
//--------------------------------------------------------------------------
// Result stage. Strobes reads, captures the returned word one cycle later
// into the named result register, and raises done, error and abort pulses.
//--------------------------------------------------------------------------
`default_nettype none

module ecdsa_result_bank (
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire                           zeroize_i,
    ecdsa_uop_if.sink                     uop,
    input  wire                           input_err_i,
    input  wire                           valid_i,
    input  wire ecdsa_ctrl_pkg::operand_t pm_rd_data_i,
    output logic                          pm_rd_en_o,
    output ecdsa_ctrl_pkg::operand_t      pubkey_x_o,
    output ecdsa_ctrl_pkg::operand_t      pubkey_y_o,
    output ecdsa_ctrl_pkg::operand_t      r_o,
    output ecdsa_ctrl_pkg::operand_t      s_o,
    output ecdsa_ctrl_pkg::operand_t      verify_r_o,
    output logic                          done_o,
    output logic                          error_o
);

    logic                    cap_en_q;
    ecdsa_ctrl_pkg::reg_id_e cap_id_q;
    logic                    err_q;
    logic                    valid_q;
    logic                    sign_zero;
    logic                    err;

    assign pm_rd_en_o = uop.issue && (uop.instr.opcode == ecdsa_ctrl_pkg::UOP_RD_CORE);

    // a signature with r or s equal to zero is rejected
    assign sign_zero = cap_en_q && (uop.proc == ecdsa_ctrl_pkg::PROC_SIGN) &&
                       ((cap_id_q == ecdsa_ctrl_pkg::R_ID) || (cap_id_q == ecdsa_ctrl_pkg::S_ID)) &&
                       (pm_rd_data_i == '0);

    assign err       = input_err_i || sign_zero;
    assign error_o   = err && !err_q;
    assign uop.abort = error_o;
    assign done_o    = valid_i && !valid_q;

    //------------------------------------------------------------------------
    // capture and edge registers
    //------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cap_en_q   <= 1'b0;
            cap_id_q   <= ecdsa_ctrl_pkg::CONST_ZERO_ID;
            err_q      <= 1'b0;
            valid_q    <= 1'b0;
            pubkey_x_o <= '0;
            pubkey_y_o <= '0;
            r_o        <= '0;
            s_o        <= '0;
            verify_r_o <= '0;
        end else if (zeroize_i) begin
            cap_en_q   <= 1'b0;
            cap_id_q   <= ecdsa_ctrl_pkg::CONST_ZERO_ID;
            err_q      <= 1'b0;
            valid_q    <= 1'b0;
            pubkey_x_o <= '0;
            pubkey_y_o <= '0;
            r_o        <= '0;
            s_o        <= '0;
            verify_r_o <= '0;
        end else begin
            // the read micro-op may be gone by the time data returns
            cap_en_q <= pm_rd_en_o;
            cap_id_q <= uop.instr.reg_id;
            err_q    <= err;
            valid_q  <= valid_i;
            if (cap_en_q) begin
                case (cap_id_q)
                    ecdsa_ctrl_pkg::PUBKEYX_ID:  pubkey_x_o <= pm_rd_data_i;
                    ecdsa_ctrl_pkg::PUBKEYY_ID:  pubkey_y_o <= pm_rd_data_i;
                    ecdsa_ctrl_pkg::R_ID:        r_o        <= pm_rd_data_i;
                    ecdsa_ctrl_pkg::S_ID:        s_o        <= pm_rd_data_i;
                    ecdsa_ctrl_pkg::VERIFY_R_ID: verify_r_o <= pm_rd_data_i;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- ecdsa_sequencer.sv
//--------------------------------------------------------------------------
// Execute stage. Dispatches a command to its micro-program, steps the
// program counter one micro-op per four-cycle slot and stalls on busy.
//--------------------------------------------------------------------------
`default_nettype none

module ecdsa_sequencer (
    input  wire                          clk,
    input  wire                          reset_n,
    input  wire                          zeroize_i,
    input  wire ecdsa_ctrl_pkg::cmd_e    cmd_i,
    input  wire                          pm_busy_i,
    output logic                         ready_o,
    output logic                         valid_o,
    output ecdsa_ctrl_pkg::pm_cmd_e      pm_cmd_o,
    ecdsa_uop_if.seq                     uop
);

    logic [ecdsa_ctrl_pkg::PROG_ADDR_W-1:0] prog_addr;
    logic [1:0]                             slot_q;
    logic                                   valid_q;
    ecdsa_ctrl_pkg::proc_e                  proc_q;
    logic                                   running;
    logic                                   at_end;
    logic                                   issue;

    // the rom word for an address is ready one slot later, so slot 0 issues
    // the micro-op fetched during the previous slot
    ecdsa_program_rom program_rom_i (
        .clk     (clk),
        .reset_n (reset_n),
        .addr_i  (prog_addr),
        .instr_o (uop.instr)
    );

    assign running = (prog_addr != ecdsa_ctrl_pkg::DSA_NOP);
    assign at_end  = (prog_addr == ecdsa_ctrl_pkg::DSA_KG_E)  ||
                     (prog_addr == ecdsa_ctrl_pkg::DSA_SGN_E) ||
                     (prog_addr == ecdsa_ctrl_pkg::DSA_VER_E);

    assign issue     = running && (slot_q == 2'd0) && !uop.abort;
    assign uop.issue = issue;
    assign uop.proc  = proc_q;

    assign pm_cmd_o = (issue && uop.instr.opcode == ecdsa_ctrl_pkg::UOP_PM) ?
                      uop.instr.pm_cmd : ecdsa_ctrl_pkg::PM_NONE;

    assign ready_o = !running && !pm_busy_i;
    assign valid_o = valid_q;

    //------------------------------------------------------------------------
    // program counter and slot counter
    //------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prog_addr <= ecdsa_ctrl_pkg::DSA_NOP;
            slot_q    <= 2'd0;
            proc_q    <= ecdsa_ctrl_pkg::PROC_IDLE;
            valid_q   <= 1'b0;
        end else if (zeroize_i) begin
            prog_addr <= ecdsa_ctrl_pkg::DSA_NOP;
            slot_q    <= 2'd0;
            proc_q    <= ecdsa_ctrl_pkg::PROC_IDLE;
            valid_q   <= 1'b0;
        end else if (uop.abort) begin
            // valid stays low after an aborted command
            prog_addr <= ecdsa_ctrl_pkg::DSA_NOP;
            slot_q    <= 2'd0;
            proc_q    <= ecdsa_ctrl_pkg::PROC_IDLE;
        end else if (pm_busy_i) begin
            slot_q <= ecdsa_ctrl_pkg::SLOT_LAST;
        end else if (!running) begin
            slot_q <= 2'd0;
            case (cmd_i)
                ecdsa_ctrl_pkg::KEYGEN: begin
                    prog_addr <= ecdsa_ctrl_pkg::DSA_KG_S;
                    proc_q    <= ecdsa_ctrl_pkg::PROC_KEYGEN;
                    valid_q   <= 1'b0;
                end
                ecdsa_ctrl_pkg::SIGN: begin
                    prog_addr <= ecdsa_ctrl_pkg::DSA_SGN_S;
                    proc_q    <= ecdsa_ctrl_pkg::PROC_SIGN;
                    valid_q   <= 1'b0;
                end
                ecdsa_ctrl_pkg::VERIFY: begin
                    prog_addr <= ecdsa_ctrl_pkg::DSA_VER_S;
                    proc_q    <= ecdsa_ctrl_pkg::PROC_VERIFY;
                    valid_q   <= 1'b0;
                end
                default: begin
                    prog_addr <= ecdsa_ctrl_pkg::DSA_NOP;
                end
            endcase
        end else if (slot_q != ecdsa_ctrl_pkg::SLOT_LAST) begin
            slot_q <= slot_q + 2'd1;
        end else begin
            slot_q <= 2'd0;
            if (at_end) begin
                prog_addr <= ecdsa_ctrl_pkg::DSA_NOP;
                proc_q    <= ecdsa_ctrl_pkg::PROC_IDLE;
                valid_q   <= 1'b1;
            end else begin
                prog_addr <= prog_addr + 6'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- ecdsa_uop_if.sv
//--------------------------------------------------------------------------
// Current micro-op as seen by the operand and result stages, plus the
// abort level that the result stage returns to the sequencer.
//--------------------------------------------------------------------------
`default_nettype none

interface ecdsa_uop_if;

    ecdsa_ctrl_pkg::instr_t instr;
    logic                   issue;
    ecdsa_ctrl_pkg::proc_e  proc;
    logic                   abort;

    modport seq (
        output instr,
        output issue,
        output proc,
        input  abort
    );

    modport sink (
        input  instr,
        input  issue,
        input  proc,
        output abort
    );

endinterface

`default_nettype wire

//--- ecdsa_vectors.txt
// the first number is the test count, then one test per line
// cmd (1 keygen 2 sign 3 verify) msg privkey pubkey_x pubkey_y r s
// then ret_x ret_y ret_r ret_s ret_verify_r from the model and expect (0 done 1 error)
a
1 0 1d2c3b4a 0 0 0 0 11aa22bb 33cc44dd 0 0 0 0
2 123456789abcdef 5a5a5a5a 0 0 0 0 0 0 7e7e7e7e 6d6d6d6d 0 0
2 ffffffffffffffffffffffffffffffffffffffffffffffffc7634d81f4372ddf581a0db248b0a77aecec196accc52978 2b 0 0 0 0 0 0 1f2e3d4c 5b6a7988 0 0
3 abcdef01 0 4c4c4c4c 3b3b3b3b 1234 5678 0 0 0 0 9abcdef0 0
2 77 0 0 0 0 0 0 0 1 1 0 1
2 77 ffffffffffffffffffffffffffffffffffffffffffffffffc7634d81f4372ddf581a0db248b0a77aecec196accc52973 0 0 0 0 0 0 1 1 0 1
3 77 0 1 1 ffffffffffffffffffffffffffffffffffffffffffffffffc7634d81f4372ddf581a0db248b0a77aecec196accc52973 5 0 0 0 0 1 1
3 77 0 fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffeffffffff0000000000000000ffffffff 1 9 5 0 0 0 0 1 1
2 99 3c 0 0 0 0 0 0 4d4d 0 0 1
1 0 2d 0 0 0 0 5e5e5e5e 6f6f6f6f 0 0 0 0

//--- tb_ecdsa_ctrl.sv
//--------------------------------------------------------------------------
// Self-checking testbench for the ECDSA command controller. Runs the tests
// listed in ecdsa_vectors.txt against a model of the point-multiply unit.
//--------------------------------------------------------------------------
`default_nettype none

module tb_ecdsa_ctrl;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS    = 13;
    localparam int MAX_TEST = 16;

    // P-384 group order
    localparam logic [383:0] Q = {
        192'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF,
        192'hC7634D81_F4372DDF_581A0DB2_48B0A77A_ECEC196A_CCC52973
    };

    logic                    clk = 1'b0;
    logic                    reset_n;
    logic                    zeroize_i;
    ecdsa_ctrl_pkg::cmd_e    cmd_i;
    logic [383:0]            msg_i;
    logic [383:0]            privkey_i;
    logic [383:0]            pubkey_x_i;
    logic [383:0]            pubkey_y_i;
    logic [383:0]            r_i;
    logic [383:0]            s_i;
    logic                    ready_o;
    logic                    valid_o;
    logic                    done_o;
    logic                    error_o;
    logic [383:0]            pubkey_x_o;
    logic [383:0]            pubkey_y_o;
    logic [383:0]            r_o;
    logic [383:0]            s_o;
    logic [383:0]            verify_r_o;
    logic                    pm_wr_en_o;
    logic                    pm_rd_en_o;
    logic [5:0]              pm_addr_o;
    logic [383:0]            pm_wr_data_o;
    ecdsa_ctrl_pkg::pm_cmd_e pm_cmd_o;
    logic [383:0]            pm_rd_data_i = '0;
    logic                    pm_busy_i = 1'b0;

    logic [383:0]            vec_mem [0:MAX_TEST*WORDS];
    logic [383:0]            wr_mem [0:63];
    int                      wr_test [0:63] = '{default: -1};
    logic [383:0]            rd_vals [0:63];
    ecdsa_ctrl_pkg::pm_cmd_e last_pm = ecdsa_ctrl_pkg::PM_NONE;
    int                      busy_left = 0;
    integer                  seed = 32'h8a77bab2;
    int                      num_tests = 0;
    int                      cur_test = -1;
    int                      test_idx;
    int                      mismatches = 0;
    int                      failures = 0;
    bit                      loaded = 1'b0;

    ecdsa_ctrl_top dut_i (.*);

    always #10 clk = ~clk;

    //------------------------------------------------------------------------
    // point-multiply unit model
    //------------------------------------------------------------------------
    always @(negedge clk) begin
        if (pm_wr_en_o) begin
            wr_mem[pm_addr_o]  = pm_wr_data_o;
            wr_test[pm_addr_o] = cur_test;
        end
        // read data is in place for the capture cycle that follows
        if (pm_rd_en_o) begin
            pm_rd_data_i <= rd_vals[pm_addr_o];
        end
        if (pm_cmd_o != ecdsa_ctrl_pkg::PM_NONE) begin
            last_pm   = pm_cmd_o;
            busy_left = {$random(seed)} % 8;
        end else if (busy_left > 0) begin
            busy_left = busy_left - 1;
        end
        pm_busy_i <= (busy_left > 0);
    end

    initial begin
        wait (loaded);
        repeat (num_tests * 2000 + 20) @(posedge clk);
        $display("timeout, the tests did not finish within %0d cycles", num_tests * 2000 + 20);
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [383:0] reduce_mod_q(input logic [383:0] m);
        return (m >= Q) ? m - Q : m;
    endfunction

    task automatic compare_value(input string name, input logic [383:0] got,
                                 input logic [383:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%0t: %s", $time, what);
            failures++;
        end
    endtask

    task automatic check_write(input int t, input int addr, input logic [383:0] exp);
        expect_true(wr_test[addr] == t,
                    $sformatf("test %0d wrote nothing to operand address %0d", t, addr));
        compare_value($sformatf("pm_wr_data_o[%0d]", addr), wr_mem[addr], exp);
    endtask

    //------------------------------------------------------------------------
    // one vector line from command to done or error
    //------------------------------------------------------------------------
    task automatic run_test(input int t);
        int                      base;
        logic [1:0]              cmd;
        logic                    expect_err;
        ecdsa_ctrl_pkg::pm_cmd_e exp_pm;
        base       = 1 + t * WORDS;
        cmd        = vec_mem[base][1:0];
        expect_err = vec_mem[base + 12][0];
        while (!ready_o) begin
            @(negedge clk);
        end
        cur_test   = t;
        wr_test    = '{default: -1};
        last_pm    = ecdsa_ctrl_pkg::PM_NONE;
        // returned words by operand address x 6, y 7, r 4, s 5, verify_r 8
        rd_vals[6] = vec_mem[base + 7];
        rd_vals[7] = vec_mem[base + 8];
        rd_vals[4] = vec_mem[base + 9];
        rd_vals[5] = vec_mem[base + 10];
        rd_vals[8] = vec_mem[base + 11];
        msg_i      <= vec_mem[base + 1];
        privkey_i  <= vec_mem[base + 2];
        pubkey_x_i <= vec_mem[base + 3];
        pubkey_y_i <= vec_mem[base + 4];
        r_i        <= vec_mem[base + 5];
        s_i        <= vec_mem[base + 6];
        cmd_i      <= ecdsa_ctrl_pkg::cmd_e'(cmd);
        @(negedge clk);
        cmd_i <= ecdsa_ctrl_pkg::NOP_CMD;
        while (!done_o && !error_o) begin
            @(negedge clk);
        end
        if (expect_err) begin
            expect_true(error_o && !done_o, $sformatf("test %0d completed, error expected", t));
            @(negedge clk);
            expect_true(!error_o, $sformatf("test %0d error pulse longer than one cycle", t));
            repeat (8) begin
                expect_true(!done_o && !valid_o, $sformatf("test %0d done after error", t));
                expect_true(!pm_wr_en_o && !pm_rd_en_o &&
                            (pm_cmd_o == ecdsa_ctrl_pkg::PM_NONE),
                            $sformatf("test %0d strobe issued after abort", t));
                @(negedge clk);
            end
            expect_true(ready_o, $sformatf("test %0d ready stays low after error", t));
        end else begin
            expect_true(done_o && !error_o, $sformatf("test %0d raised error, done expected", t));
            expect_true(valid_o && ready_o, $sformatf("test %0d valid or ready low at done", t));
            case (cmd)
                2'd1: begin
                    exp_pm = ecdsa_ctrl_pkg::PM_KEYGEN;
                    check_write(t, 3, vec_mem[base + 2]);
                    compare_value("pubkey_x_o", pubkey_x_o, rd_vals[6]);
                    compare_value("pubkey_y_o", pubkey_y_o, rd_vals[7]);
                end
                2'd2: begin
                    exp_pm = ecdsa_ctrl_pkg::PM_SIGN;
                    check_write(t, 2, reduce_mod_q(vec_mem[base + 1]));
                    check_write(t, 3, vec_mem[base + 2]);
                    compare_value("r_o", r_o, rd_vals[4]);
                    compare_value("s_o", s_o, rd_vals[5]);
                end
                default: begin
                    exp_pm = ecdsa_ctrl_pkg::PM_VERIFY;
                    check_write(t, 2, vec_mem[base + 1]);
                    check_write(t, 4, vec_mem[base + 5]);
                    check_write(t, 5, vec_mem[base + 6]);
                    check_write(t, 6, vec_mem[base + 3]);
                    check_write(t, 7, vec_mem[base + 4]);
                    compare_value("verify_r_o", verify_r_o, rd_vals[8]);
                end
            endcase
            compare_value("pm_cmd_o", 384'(last_pm), 384'(exp_pm));
            @(negedge clk);
            expect_true(!done_o && valid_o, $sformatf("test %0d done pulse or valid wrong", t));
        end
    endtask

    initial begin
        reset_n    <= 1'b0;
        zeroize_i  <= 1'b0;
        cmd_i      <= ecdsa_ctrl_pkg::NOP_CMD;
        msg_i      <= '0;
        privkey_i  <= '0;
        pubkey_x_i <= '0;
        pubkey_y_i <= '0;
        r_i        <= '0;
        s_i        <= '0;
        $readmemh("ecdsa_vectors.txt", vec_mem);
        num_tests = int'(vec_mem[0][31:0]);
        loaded    = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        compare_value("ready_o", 384'(ready_o), 384'd1);
        compare_value("valid_o", 384'(valid_o), '0);
        compare_value("done_o", 384'(done_o), '0);
        compare_value("error_o", 384'(error_o), '0);
        compare_value("pm_wr_en_o", 384'(pm_wr_en_o), '0);
        compare_value("pm_rd_en_o", 384'(pm_rd_en_o), '0);
        compare_value("pm_cmd_o", 384'(pm_cmd_o), '0);
        for (test_idx = 0; test_idx < num_tests; test_idx++) begin
            run_test(test_idx);
        end
        // replaying the completing tests leaves a result in every output register
        for (test_idx = 0; test_idx < num_tests; test_idx++) begin
            if (!vec_mem[1 + test_idx * WORDS + 12][0]) begin
                run_test(test_idx);
            end
        end
        zeroize_i <= 1'b1;
        @(negedge clk);
        zeroize_i <= 1'b0;
        compare_value("pubkey_x_o", pubkey_x_o, '0);
        compare_value("pubkey_y_o", pubkey_y_o, '0);
        compare_value("r_o", r_o, '0);
        compare_value("s_o", s_o, '0);
        compare_value("verify_r_o", verify_r_o, '0);
        compare_value("valid_o", 384'(valid_o), '0);
        $display("%0d tests, %0d mismatches, %0d other failures",
                 num_tests, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
